// ==== design/mem_cfg_pkg.sv ====
// ****************************************
// memory path configuration
// word address and word data widths
// ****************************************
`default_nettype none

package mem_cfg_pkg;

    // word address width, 1024 words
    parameter int SDRAMW = 10;

    // memory word width
    parameter int MEMDW = 16;

    // number of words in the array
    parameter int MEMWORDS = 1 << SDRAMW;

endpackage

`default_nettype wire

// ==== design/mem_ops_pkg.sv ====
// ****************************************
// memory operation and FSM encodings
// ****************************************
`default_nettype none

package mem_ops_pkg;

    // polarity follows req_rnw, high means read
    typedef enum logic {
        OP_WR = 1'b0,
        OP_RD = 1'b1
    } mem_op_e;

    // controller FSM
    typedef enum logic [1:0] {
        IDLE = 2'd0,   // waiting for mem_req
        WAIT = 2'd1,   // latency count
        DONE = 2'd2    // one-cycle done strobe
    } ctrl_state_e;

    // arbiter ownership
    typedef enum logic {
        FREE = 1'b0,
        BUSY = 1'b1
    } arb_state_e;

endpackage

`default_nettype wire

// ==== design/ram_rq.sv ====
// ****************************************
// request adapter, CPU chip select to one
// memory request per rising edge
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module ram_rq #(
    parameter int AW     = 9,
    parameter int DW     = 16,
    parameter int FASTWR = 0    // ack writes as soon as the arbiter takes them
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire [AW-1:0]                addr,
    input  wire [mem_cfg_pkg::SDRAMW-1:0] offset,  // fixed while running
    input  wire                         addr_ok,     // chip select level
    input  wire                         wrin,
    input  wire [DW-1:0]                wrdata,
    input  wire [mem_cfg_pkg::MEMDW-1:0] din,     // read word, shared bus
    input  wire                         we,          // request taken
    input  wire                         dst,         // din valid
    input  wire                         din_ok,      // access finished
    output logic                        req,
    output logic                        req_rnw,
    output logic [mem_cfg_pkg::SDRAMW-1:0] sdram_addr,
    output logic [mem_cfg_pkg::MEMDW-1:0]  wdata,
    output logic                        data_ok,
    output logic [DW-1:0]               dout
);

    import mem_cfg_pkg::*;

    logic last_cs;     // addr_ok one cycle back
    logic cs_rise;     // registered rising edge of addr_ok
    logic pending;     // rise seen while an access was still running
    logic inflight;    // taken by the arbiter, din_ok not yet seen
    logic busy;
    logic issue;

    assign busy  = req || inflight;
    assign issue = (cs_rise || pending) && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_cs  <= 1'b0;
            cs_rise  <= 1'b0;
            pending  <= 1'b0;
            inflight <= 1'b0;
            req      <= 1'b0;
            req_rnw  <= 1'b1;
            data_ok  <= 1'b0;
            dout     <= '0;
        end else begin
            last_cs <= addr_ok;
            cs_rise <= addr_ok && !last_cs;
            if (!addr_ok) data_ok <= 1'b0;    // four-phase return to zero

            if (we) begin
                req      <= 1'b0;     // drop on the accept edge
                inflight <= 1'b1;
                if (FASTWR != 0 && !req_rnw)
                    data_ok <= 1'b1;  // early write ack
            end

            if (dst) dout <= din[DW-1:0];

            if (din_ok) begin
                inflight <= 1'b0;
                // fast writes were already acked on we
                if (FASTWR == 0 || req_rnw) data_ok <= 1'b1;
            end

            if (issue) begin
                req     <= 1'b1;
                req_rnw <= ~wrin;
                data_ok <= 1'b0;
                pending <= 1'b0;
            end else if (cs_rise) begin
                pending <= 1'b1;      // wait for the running write
            end
        end
    end

    // address and write word, captured when the request goes out
    always_ff @(posedge clk) begin
        if (issue) begin
            sdram_addr <= SDRAMW'(addr) + offset;
            wdata      <= MEMDW'(wrdata);    // zero extended
        end
    end

endmodule

`default_nettype wire

// ==== design/slot_arbiter.sv ====
// ****************************************
// two-slot round-robin arbiter
// routes controller strobes to the owner
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module slot_arbiter (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            req_0,
    input  wire                            req_1,
    input  wire                            rnw_0,
    input  wire                            rnw_1,
    input  wire [mem_cfg_pkg::SDRAMW-1:0]  addr_0,
    input  wire [mem_cfg_pkg::SDRAMW-1:0]  addr_1,
    input  wire [mem_cfg_pkg::MEMDW-1:0]   wdata_0,
    input  wire [mem_cfg_pkg::MEMDW-1:0]   wdata_1,
    input  wire                            accept,     // from controller
    input  wire                            mem_dst,
    input  wire                            mem_done,
    input  wire [mem_cfg_pkg::MEMDW-1:0]   mem_rdata,
    output logic                           we_0,
    output logic                           we_1,
    output logic                           dst_0,
    output logic                           dst_1,
    output logic                           din_ok_0,
    output logic                           din_ok_1,
    output logic [mem_cfg_pkg::MEMDW-1:0]  din,
    output logic                           mem_req,
    output mem_ops_pkg::mem_op_e           mem_op,
    output logic [mem_cfg_pkg::SDRAMW-1:0] mem_addr,
    output logic [mem_cfg_pkg::MEMDW-1:0]  mem_wdata
);

    import mem_cfg_pkg::*;
    import mem_ops_pkg::*;

    arb_state_e state;
    logic       last_srv;   // slot served last, also the current owner
    logic       any_req;
    logic       pick_1;     // winner of this round

    assign any_req = req_0 || req_1;
    // slot 1 wins when alone, or when both ask and slot 0 went last
    assign pick_1  = req_1 && (!req_0 || !last_srv);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= FREE;
            mem_req  <= 1'b0;
            last_srv <= 1'b1;     // slot 0 first after reset
        end else begin
            case (state)
                FREE: begin
                    if (any_req) begin
                        state    <= BUSY;
                        mem_req  <= 1'b1;
                        last_srv <= pick_1;
                    end
                end
                BUSY: begin
                    if (mem_done) begin   // release, next grant one edge later
                        state   <= FREE;
                        mem_req <= 1'b0;
                    end
                end
                default: state <= FREE;
            endcase
        end
    end

    // request fields held for the whole access
    always_ff @(posedge clk) begin
        if (state == FREE && any_req) begin
            mem_op    <= mem_op_e'(pick_1 ? rnw_1 : rnw_0);
            mem_addr  <= pick_1 ? addr_1 : addr_0;
            mem_wdata <= pick_1 ? wdata_1 : wdata_0;
        end
    end

    // strobes back to the owner only, no added cycle
    assign we_0     = accept && !last_srv;
    assign we_1     = accept && last_srv;
    assign dst_0    = mem_dst && !last_srv;
    assign dst_1    = mem_dst && last_srv;
    assign din_ok_0 = mem_done && !last_srv;
    assign din_ok_1 = mem_done && last_srv;
    assign din      = mem_rdata;   // both slots see the read bus

endmodule

`default_nettype wire

// ==== design/mem_ctrl.sv ====
// ****************************************
// fixed-latency memory controller
// with an on-chip word array
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module mem_ctrl #(
    parameter int LATENCY = 3    // accept to dst, 1 to 7
) (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            mem_req,
    input  mem_ops_pkg::mem_op_e           mem_op,
    input  wire [mem_cfg_pkg::SDRAMW-1:0]  mem_addr,
    input  wire [mem_cfg_pkg::MEMDW-1:0]   mem_wdata,
    output logic                           accept,
    output logic                           mem_dst,
    output logic                           mem_done,
    output logic [mem_cfg_pkg::MEMDW-1:0]  mem_rdata
);

    import mem_cfg_pkg::*;
    import mem_ops_pkg::*;

    localparam int CW = 3;   // enough for LATENCY up to 7

    logic [MEMDW-1:0] mem [0:MEMWORDS-1];   // stands in for the SDRAM chip
    ctrl_state_e      state;
    logic [CW-1:0]    cnt;       // cycles left before dst

    // accept in the same cycle the request is seen while idle
    assign accept   = (state == IDLE) && mem_req;
    assign mem_dst  = (state == WAIT) && (cnt == '0);
    assign mem_done = (state == DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= WAIT;
                        cnt   <= CW'(LATENCY - 1);
                    end
                end
                WAIT: begin
                    if (cnt == '0)
                        state <= DONE;    // dst this cycle
                    else
                        cnt <= cnt - 1'b1;
                end
                DONE: begin
                    state <= IDLE;        // arbiter releases on this edge too
                end
                default: state <= IDLE;
            endcase
        end
    end

    // array access happens on accept, read word held until the next read
    always_ff @(posedge clk) begin
        if (accept) begin
            if (mem_op == OP_WR)
                mem[mem_addr] <= mem_wdata;
            else
                mem_rdata <= mem[mem_addr];
        end
    end

endmodule

`default_nettype wire

// ==== design/mem_sys_top.sv ====
// ****************************************
// shared memory subsystem, two requesters
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module mem_sys_top #(
    parameter int AW0     = 9,
    parameter int AW1     = 8,
    parameter int DW0     = 16,
    parameter int DW1     = 8,
    parameter int FASTWR0 = 0,
    parameter int FASTWR1 = 1,    // slot 1 gets early write acks
    parameter int LATENCY = 3
) (
    input  wire                           clk,
    input  wire                           rst,
    // slot 0
    input  wire [AW0-1:0]                 addr_0,
    input  wire [mem_cfg_pkg::SDRAMW-1:0] offset_0,
    input  wire                           addr_ok_0,
    input  wire                           wrin_0,
    input  wire [DW0-1:0]                 wrdata_0,
    output logic                          data_ok_0,
    output logic [DW0-1:0]                dout_0,
    // slot 1
    input  wire [AW1-1:0]                 addr_1,
    input  wire [mem_cfg_pkg::SDRAMW-1:0] offset_1,
    input  wire                           addr_ok_1,
    input  wire                           wrin_1,
    input  wire [DW1-1:0]                 wrdata_1,
    output logic                          data_ok_1,
    output logic [DW1-1:0]                dout_1
);

    import mem_cfg_pkg::*;
    import mem_ops_pkg::*;

    // adapter to arbiter, per slot
    logic              req_0, req_1;
    logic              rnw_0, rnw_1;
    logic [SDRAMW-1:0] rq_addr_0, rq_addr_1;
    logic [MEMDW-1:0]  rq_wdata_0, rq_wdata_1;
    logic              we_0, we_1;
    logic              dst_0, dst_1;
    logic              din_ok_0, din_ok_1;
    logic [MEMDW-1:0]  din;           // shared read bus

    // arbiter to controller
    logic              mem_req;
    mem_op_e           mem_op;
    logic [SDRAMW-1:0] mem_addr;
    logic [MEMDW-1:0]  mem_wdata;
    logic              accept;
    logic              mem_dst;
    logic              mem_done;
    logic [MEMDW-1:0]  mem_rdata;

    ram_rq #(.AW(AW0), .DW(DW0), .FASTWR(FASTWR0)) u_rq0 (
        .clk(clk), .rst(rst),
        .addr(addr_0), .offset(offset_0), .addr_ok(addr_ok_0),
        .wrin(wrin_0), .wrdata(wrdata_0),
        .din(din), .we(we_0), .dst(dst_0), .din_ok(din_ok_0),
        .req(req_0), .req_rnw(rnw_0), .sdram_addr(rq_addr_0), .wdata(rq_wdata_0),
        .data_ok(data_ok_0), .dout(dout_0)
    );

    ram_rq #(.AW(AW1), .DW(DW1), .FASTWR(FASTWR1)) u_rq1 (
        .clk(clk), .rst(rst),
        .addr(addr_1), .offset(offset_1), .addr_ok(addr_ok_1),
        .wrin(wrin_1), .wrdata(wrdata_1),
        .din(din), .we(we_1), .dst(dst_1), .din_ok(din_ok_1),
        .req(req_1), .req_rnw(rnw_1), .sdram_addr(rq_addr_1), .wdata(rq_wdata_1),
        .data_ok(data_ok_1), .dout(dout_1)
    );

    slot_arbiter u_arb (
        .clk(clk), .rst(rst),
        .req_0(req_0), .req_1(req_1), .rnw_0(rnw_0), .rnw_1(rnw_1),
        .addr_0(rq_addr_0), .addr_1(rq_addr_1),
        .wdata_0(rq_wdata_0), .wdata_1(rq_wdata_1),
        .accept(accept), .mem_dst(mem_dst), .mem_done(mem_done), .mem_rdata(mem_rdata),
        .we_0(we_0), .we_1(we_1), .dst_0(dst_0), .dst_1(dst_1),
        .din_ok_0(din_ok_0), .din_ok_1(din_ok_1), .din(din),
        .mem_req(mem_req), .mem_op(mem_op), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    mem_ctrl #(.LATENCY(LATENCY)) u_ctrl (
        .clk(clk), .rst(rst),
        .mem_req(mem_req), .mem_op(mem_op), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .accept(accept), .mem_dst(mem_dst), .mem_done(mem_done), .mem_rdata(mem_rdata)
    );

endmodule

`default_nettype wire

// ==== tb/mem_sys_checker.sv ====
// ****************************************
// testbench checker, reference memory,
// read data and write-ack timing
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module mem_sys_checker #(
    parameter int AW0     = 9,
    parameter int AW1     = 8,
    parameter int DW0     = 16,
    parameter int DW1     = 8,
    parameter int FASTWR0 = 0,
    parameter int FASTWR1 = 1,
    parameter int LATENCY = 3
) (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           paired,     // both slots started together
    input  wire [7:0]                     tid_0,
    input  wire [AW0-1:0]                 addr_0,
    input  wire [mem_cfg_pkg::SDRAMW-1:0] offset_0,
    input  wire                           addr_ok_0,
    input  wire                           wrin_0,
    input  wire [DW0-1:0]                 wrdata_0,
    input  wire [mem_cfg_pkg::MEMDW-1:0]  exp_0,
    input  wire                           req_0,      // adapter request, inside the DUT
    input  wire                           data_ok_0,
    input  wire [DW0-1:0]                 dout_0,
    input  wire [7:0]                     tid_1,
    input  wire [AW1-1:0]                 addr_1,
    input  wire [mem_cfg_pkg::SDRAMW-1:0] offset_1,
    input  wire                           addr_ok_1,
    input  wire                           wrin_1,
    input  wire [DW1-1:0]                 wrdata_1,
    input  wire [mem_cfg_pkg::MEMDW-1:0]  exp_1,
    input  wire                           req_1,
    input  wire                           data_ok_1,
    input  wire [DW1-1:0]                 dout_1,
    output int                            err_cnt,
    output int                            done_cnt
);

    import mem_cfg_pkg::*;

    localparam logic [MEMDW-1:0] MASK_0 = MEMDW'((1 << DW0) - 1);
    localparam logic [MEMDW-1:0] MASK_1 = MEMDW'((1 << DW1) - 1);

    logic [MEMDW-1:0]  ref_mem [0:MEMWORDS-1];    // what the array should hold
    logic [MEMWORDS-1:0] written;
    logic [1:0]        cs_q, rq_q, ok_q;          // last sampled levels per slot
    logic [1:0]        spent;      // acked, chip select not toggled since
    logic [1:0]        pair_q, wr_q;
    logic [SDRAMW-1:0] phys_q [2];
    logic [MEMDW-1:0]  wd_q [2];
    logic [MEMDW-1:0]  exp_q [2];
    logic [7:0]        id_q [2];
    int                rq_cyc [2]; // cycle where req went high
    int                cyc;

    task automatic watch_slot(input logic s, input logic cs, input logic rq, input logic ok,
                              input logic [SDRAMW-1:0] phys, input logic wr,
                              input logic [MEMDW-1:0] wd, input logic [MEMDW-1:0] ex,
                              input logic [MEMDW-1:0] dout, input logic [MEMDW-1:0] mask,
                              input logic [7:0] id, input logic fast);
        int               lat;
        logic             bad;
        logic [MEMDW-1:0] val;
        bad = 1'b0;
        if (cs && !cs_q[s]) begin      // new access, fields held from here
            phys_q[s] = phys;
            wr_q[s]   = wr;
            wd_q[s]   = wd;
            exp_q[s]  = ex;
            id_q[s]   = id;
            pair_q[s] = paired;
            spent[s]  = 1'b0;
            rq_cyc[s] = cyc;
        end
        if (rq && !rq_q[s]) rq_cyc[s] = cyc;
        if (spent[s] && rq) begin
            $display("slot %0d raised a second request with chip select held, at %0t",
                     s, $time);
            err_cnt  = err_cnt + 1;
            spent[s] = 1'b0;
        end
        if (ok && !ok_q[s]) begin
            lat      = cyc - rq_cyc[s];
            spent[s] = 1'b1;
            done_cnt = done_cnt + 1;
            if (wr_q[s]) begin
                ref_mem[phys_q[s]] = wd_q[s];
                written[phys_q[s]] = 1'b1;
                val = wd_q[s];
                // early ack only counts when nothing else holds the arbiter
                if (fast && !pair_q[s] && lat != 2) begin
                    $display("slot %0d write ack came %0d edges after req, not 2, at %0t",
                             s, lat, $time);
                    bad = 1'b1;
                end
                if (!fast && lat < LATENCY + 3) begin
                    $display("slot %0d write ack came early, %0d edges after req, at %0t",
                             s, lat, $time);
                    bad = 1'b1;
                end
            end else begin
                val = dout;
                if (!written[phys_q[s]]) begin
                    $display("slot %0d read a word never written, 0x%h, at %0t",
                             s, phys_q[s], $time);
                    bad = 1'b1;
                end else begin
                    if (dout != (ref_mem[phys_q[s]] & mask)) begin
                        $display("[FAIL] %0t: slot %0d word 0x%h read 0x%h, expected 0x%h",
                                 $time, s, phys_q[s], dout, ref_mem[phys_q[s]] & mask);
                        bad = 1'b1;
                    end
                    if ((exp_q[s] & mask) != (ref_mem[phys_q[s]] & mask)) begin
                        $display("[FAIL] %0t: test %0d table value 0x%h, memory holds 0x%h",
                                 $time, id_q[s], exp_q[s], ref_mem[phys_q[s]]);
                        bad = 1'b1;
                    end
                end
            end
            if (bad) err_cnt = err_cnt + 1;
            $display("test %0d slot %0d %s word 0x%h data 0x%h lat %0d: %s", id_q[s], s,
                     wr_q[s] ? "wr" : "rd", phys_q[s], val, lat, bad ? "fail" : "pass");
        end
        cs_q[s] = cs;
        rq_q[s] = rq;
        ok_q[s] = ok;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            cs_q    = '0;
            rq_q    = '0;
            ok_q    = '0;
            spent   = '0;
            written = '0;
        end else begin
            watch_slot(1'b0, addr_ok_0, req_0, data_ok_0, SDRAMW'(addr_0) + offset_0, wrin_0,
                       MEMDW'(wrdata_0), exp_0, MEMDW'(dout_0), MASK_0, tid_0, FASTWR0 != 0);
            watch_slot(1'b1, addr_ok_1, req_1, data_ok_1, SDRAMW'(addr_1) + offset_1, wrin_1,
                       MEMDW'(wrdata_1), exp_1, MEMDW'(dout_1), MASK_1, tid_1, FASTWR1 != 0);
        end
        cyc = cyc + 1;
    end

endmodule

`default_nettype wire

// ==== tb/tb_mem_sys.sv ====
// ****************************************
// testbench for the shared memory subsystem
// ****************************************
`timescale 1ns/10ps
`default_nettype none

module tb_mem_sys;

    import mem_cfg_pkg::*;
    import mem_ops_pkg::*;

    localparam int AW0        = 9;
    localparam int AW1        = 8;
    localparam int DW0        = 16;
    localparam int DW1        = 8;
    localparam int LATENCY    = 3;
    localparam int RST_CYCLES = 8;

    typedef struct packed {
        logic [7:0]  id;
        logic        slot;
        logic        paired;   // runs together with the next entry, on slot 1
        mem_op_e     op;
        logic [8:0]  addr;
        logic [15:0] wdata;
        logic [15:0] expd;     // only the low DW bits count
        logic [3:0]  hold;     // cycles addr_ok stays up after data_ok
    } op_entry_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              paired;
    logic [7:0]        tid_0, tid_1;
    logic [15:0]       exp_0, exp_1;
    logic [AW0-1:0]    addr_0;
    logic [AW1-1:0]    addr_1;
    logic [SDRAMW-1:0] offset_0, offset_1;
    logic              addr_ok_0, addr_ok_1;
    logic              wrin_0, wrin_1;
    logic [DW0-1:0]    wrdata_0, dout_0;
    logic [DW1-1:0]    wrdata_1, dout_1;
    logic              data_ok_0, data_ok_1;
    int                err_cnt, done_cnt;
    op_entry_t         tbl [$];
    int                cyc = 0;
    int                limit;
    int                idx;
    int unsigned       gap;
    int unsigned       seed_val;

    always #2 clk = ~clk;    // 4 ns period

    mem_sys_top #(.AW0(AW0), .AW1(AW1), .DW0(DW0), .DW1(DW1), .FASTWR0(0), .FASTWR1(1),
                  .LATENCY(LATENCY)) u_mem_sys_top (
        .clk(clk), .rst(rst),
        .addr_0(addr_0), .offset_0(offset_0), .addr_ok_0(addr_ok_0), .wrin_0(wrin_0),
        .wrdata_0(wrdata_0), .data_ok_0(data_ok_0), .dout_0(dout_0),
        .addr_1(addr_1), .offset_1(offset_1), .addr_ok_1(addr_ok_1), .wrin_1(wrin_1),
        .wrdata_1(wrdata_1), .data_ok_1(data_ok_1), .dout_1(dout_1)
    );

    mem_sys_checker #(.AW0(AW0), .AW1(AW1), .DW0(DW0), .DW1(DW1), .FASTWR0(0), .FASTWR1(1),
                      .LATENCY(LATENCY)) u_checker (
        .clk(clk), .rst(rst), .paired(paired),
        .tid_0(tid_0), .addr_0(addr_0), .offset_0(offset_0), .addr_ok_0(addr_ok_0),
        .wrin_0(wrin_0), .wrdata_0(wrdata_0), .exp_0(exp_0), .req_0(u_mem_sys_top.req_0),
        .data_ok_0(data_ok_0), .dout_0(dout_0),
        .tid_1(tid_1), .addr_1(addr_1), .offset_1(offset_1), .addr_ok_1(addr_ok_1),
        .wrin_1(wrin_1), .wrdata_1(wrdata_1), .exp_1(exp_1), .req_1(u_mem_sys_top.req_1),
        .data_ok_1(data_ok_1), .dout_1(dout_1),
        .err_cnt(err_cnt), .done_cnt(done_cnt)
    );

    task automatic add_op(input logic [7:0] id, input logic slot, input logic pair,
                          input mem_op_e op, input logic [8:0] addr, input logic [15:0] wdata,
                          input logic [15:0] expd, input logic [3:0] hold);
        op_entry_t e;
        e.id     = id;
        e.slot   = slot;
        e.paired = pair;
        e.op     = op;
        e.addr   = addr;
        e.wdata  = wdata;
        e.expd   = expd;
        e.hold   = hold;
        tbl.push_back(e);
    endtask

    // offsets 0x040 and 0x100, word address in the comments
    task automatic fill_table();
        add_op(8'd1,  1'b0, 1'b0, OP_WR, 9'h005, 16'hA55A, 16'h0000, 4'd0);  // 0x045
        add_op(8'd2,  1'b0, 1'b0, OP_RD, 9'h005, 16'h0000, 16'hA55A, 4'd0);
        add_op(8'd3,  1'b0, 1'b0, OP_WR, 9'h0D0, 16'hBEEF, 16'h0000, 4'd0);  // 0x110
        add_op(8'd4,  1'b1, 1'b0, OP_RD, 9'h010, 16'h0000, 16'h00EF, 4'd0);  // same word
        add_op(8'd5,  1'b1, 1'b0, OP_WR, 9'h020, 16'h007C, 16'h0000, 4'd0);  // 0x120
        add_op(8'd6,  1'b0, 1'b0, OP_RD, 9'h0E0, 16'h0000, 16'h007C, 4'd0);  // upper byte 0
        add_op(8'd7,  1'b1, 1'b0, OP_WR, 9'h010, 16'h0033, 16'h0000, 4'd0);  // 0x110 again
        add_op(8'd8,  1'b0, 1'b0, OP_RD, 9'h0D0, 16'h0000, 16'h0033, 4'd0);
        add_op(8'd9,  1'b0, 1'b1, OP_WR, 9'h1FF, 16'h1234, 16'h0000, 4'd0);  // 0x23F
        add_op(8'd10, 1'b1, 1'b0, OP_WR, 9'h0FF, 16'h0099, 16'h0000, 4'd0);  // 0x1FF
        add_op(8'd11, 1'b0, 1'b1, OP_RD, 9'h1FF, 16'h0000, 16'h1234, 4'd0);
        add_op(8'd12, 1'b1, 1'b0, OP_RD, 9'h0FF, 16'h0000, 16'h0099, 4'd0);
        add_op(8'd13, 1'b0, 1'b1, OP_WR, 9'h006, 16'hC3C3, 16'h0000, 4'd0);  // 0x046
        add_op(8'd14, 1'b1, 1'b0, OP_RD, 9'h020, 16'h0000, 16'h007C, 4'd0);
        add_op(8'd15, 1'b0, 1'b1, OP_RD, 9'h005, 16'h0000, 16'hA55A, 4'd0);
        add_op(8'd16, 1'b1, 1'b0, OP_WR, 9'h030, 16'h005A, 16'h0000, 4'd0);  // 0x130
        add_op(8'd17, 1'b0, 1'b0, OP_RD, 9'h006, 16'h0000, 16'hC3C3, 4'd5);  // held chip select
        add_op(8'd18, 1'b1, 1'b0, OP_RD, 9'h030, 16'h0000, 16'h005A, 4'd4);
        add_op(8'd19, 1'b1, 1'b0, OP_WR, 9'h040, 16'h00E1, 16'h0000, 4'd3);  // 0x140
        add_op(8'd20, 1'b0, 1'b0, OP_RD, 9'h100, 16'h0000, 16'h00E1, 4'd0);
    endtask

    // one four-phase handshake on the entry's slot
    task automatic run_access(input op_entry_t e);
        @(posedge clk);
        if (e.slot == 1'b0) begin
            addr_0    <= e.addr[AW0-1:0];
            wrin_0    <= (e.op == OP_WR);
            wrdata_0  <= e.wdata[DW0-1:0];
            exp_0     <= e.expd;
            tid_0     <= e.id;
            addr_ok_0 <= 1'b1;
            do @(posedge clk); while (!data_ok_0);
            repeat (e.hold) @(posedge clk);
            addr_ok_0 <= 1'b0;
            do @(posedge clk); while (data_ok_0);   // back to zero before the next one
        end else begin
            addr_1    <= e.addr[AW1-1:0];
            wrin_1    <= (e.op == OP_WR);
            wrdata_1  <= e.wdata[DW1-1:0];
            exp_1     <= e.expd;
            tid_1     <= e.id;
            addr_ok_1 <= 1'b1;
            do @(posedge clk); while (!data_ok_1);
            repeat (e.hold) @(posedge clk);
            addr_ok_1 <= 1'b0;
            do @(posedge clk); while (data_ok_1);
        end
    endtask

    // run limit from the table length
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (limit > 0 && cyc >= limit) begin
            $display("timeout: run hung waiting for data_ok after %0d cycles", cyc);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        rst       <= 1'b1;
        paired    <= 1'b0;
        tid_0     <= '0;
        tid_1     <= '0;
        exp_0     <= '0;
        exp_1     <= '0;
        addr_0    <= '0;
        addr_1    <= '0;
        offset_0  <= 10'h040;
        offset_1  <= 10'h100;
        addr_ok_0 <= 1'b0;
        addr_ok_1 <= 1'b0;
        wrin_0    <= 1'b0;
        wrin_1    <= 1'b0;
        wrdata_0  <= '0;
        wrdata_1  <= '0;
        limit     = 0;
        seed_val  = $urandom(32'h5ec1);
        fill_table();
        limit = RST_CYCLES + tbl.size() * (LATENCY + 12) * 2;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        idx = 0;
        while (idx < tbl.size()) begin
            gap = $urandom % 4;    // idle stretch between accesses
            repeat (gap) @(posedge clk);
            if (tbl[idx].paired && idx + 1 < tbl.size()) begin
                paired <= 1'b1;
                fork
                    run_access(tbl[idx]);
                    run_access(tbl[idx + 1]);
                join
                paired <= 1'b0;
                idx = idx + 2;
            end else begin
                run_access(tbl[idx]);
                idx = idx + 1;
            end
        end
        repeat (4) @(posedge clk);
        if (done_cnt != tbl.size())
            $display("only %0d of %0d accesses completed", done_cnt, tbl.size());
        $display("summary: %0d of %0d accesses done, %0d errors", done_cnt, tbl.size(), err_cnt);
        if (err_cnt == 0 && done_cnt == tbl.size()) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
design/mem_cfg_pkg.sv
design/mem_ops_pkg.sv
design/ram_rq.sv
design/slot_arbiter.sv
design/mem_ctrl.sv
design/mem_sys_top.sv
tb/mem_sys_checker.sv
tb/tb_mem_sys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the shared memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mem_sys -f src.f -o sim_mem_sys
./obj_dir/sim_mem_sys | tee sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
